// ==== design/rf_settings.svh ====
// register file geometry for the operand-fetch block
// word width, register count and index width

`ifndef RF_SETTINGS_SVH
`define RF_SETTINGS_SVH

// register word width in bits
`define RF_WIDTH 32

// number of integer registers, including register zero
`define RF_ELS 32

// index width, log2 of the register count
`define RF_ADDR_W 5

`endif

// ==== design/mem_pkg.sv ====
// memory geometry types
// register word and register index shared by storage and bypass logic

`default_nettype none

package mem_pkg;

`include "rf_settings.svh"

   // one architectural register value
   typedef logic [`RF_WIDTH-1:0] word_t;

   // index into the register array
   typedef logic [`RF_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== design/operand_pkg.sv ====
// operand-fetch types
// source selection for each read port and the rule that picks it

`default_nettype none

package operand_pkg;

`include "rf_settings.svh"

   // where a read port takes its result from in the cycle after the strobe
   typedef enum logic [1:0] {
      SRC_MEM    = 2'd0,
      SRC_BYPASS = 2'd1,
      SRC_ZERO   = 2'd2
   } src_sel_e;

   // register zero wins over everything, then a same-cycle write
   function automatic src_sel_e pick_src(input logic [`RF_ADDR_W-1:0] r_addr,
                                         input logic                  w_v,
                                         input logic [`RF_ADDR_W-1:0] w_addr);
      if (r_addr == '0)
         return SRC_ZERO;
      else if (w_v && (r_addr == w_addr))
         return SRC_BYPASS;
      else
         return SRC_MEM;
   endfunction

endpackage

`default_nettype wire

// ==== design/mem_2r1w_sync.sv ====
// two-read one-write register storage
// writes land on the clock edge, reads are registered one cycle after the strobe

`timescale 1ns/1ps
`default_nettype none

`include "rf_settings.svh"

module mem_2r1w_sync #(
   parameter int width_p = `RF_WIDTH,
   parameter int els_p   = `RF_ELS
)(
   input  wire logic            clk_i,
   input  wire logic            rst_i,

   input  wire logic            w_v_i,
   input  mem_pkg::addr_t       w_addr_i,
   input  mem_pkg::word_t       w_data_i,

   input  wire logic            r0_v_i,
   input  mem_pkg::addr_t       r0_addr_i,
   output mem_pkg::word_t       r0_data_o,

   input  wire logic            r1_v_i,
   input  mem_pkg::addr_t       r1_addr_i,
   output mem_pkg::word_t       r1_data_o
);

   import mem_pkg::*;

   // storage array, contents undefined until written
   logic [width_p-1:0] mem_r [els_p];

   // read ports gathered so both share one body
   logic  [1:0] rd_v;
   addr_t       rd_addr [2];
   word_t       rd_data [2];

   assign rd_v[0]    = r0_v_i;
   assign rd_v[1]    = r1_v_i;
   assign rd_addr[0] = r0_addr_i;
   assign rd_addr[1] = r1_addr_i;

   assign r0_data_o = rd_data[0];
   assign r1_data_o = rd_data[1];

   // write port
   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         mem_r[w_addr_i] <= w_data_i;
      end
   end

   for (genvar i = 0; i < 2; i++)
   begin : g_rd

      word_t data_r;

      // output register holds until the next strobe
      always_ff @(posedge clk_i)
      begin
         if (rst_i)
         begin
            data_r <= '0;
         end
         else if (rd_v[i])
         begin
            data_r <= mem_r[rd_addr[i]];
         end
      end

      assign rd_data[i] = data_r;

      // the bypass unit must keep a read off the address being written
      a_no_rw_same_addr : assert property (
         @(posedge clk_i) disable iff (rst_i)
         (w_v_i && rd_v[i]) |-> (rd_addr[i] != w_addr_i)
      )
      else $error("read port %0d hits write address %0h", i, w_addr_i);

   end

   a_w_addr_range : assert property (
      @(posedge clk_i) disable iff (rst_i)
      w_v_i |-> (int'(w_addr_i) < els_p)
   )
   else $error("write address %0h outside %0d entries", w_addr_i, els_p);

endmodule

`default_nettype wire

// ==== design/operand_bypass.sv ====
// operand bypass and register-zero handling
// steers each read to memory, the same-cycle write data or zero

`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
   input  wire logic            clk_i,
   input  wire logic            rst_i,

   // write request
   input  wire logic            w_v_i,
   input  mem_pkg::addr_t       w_addr_i,
   input  mem_pkg::word_t       w_data_i,

   // read requests
   input  wire logic            r0_v_i,
   input  mem_pkg::addr_t       r0_addr_i,
   input  wire logic            r1_v_i,
   input  mem_pkg::addr_t       r1_addr_i,

   // registered data from the storage array
   input  mem_pkg::word_t       mem_r0_data_i,
   input  mem_pkg::word_t       mem_r1_data_i,

   // filtered strobes to the storage array
   output logic                 mem_w_v_o,
   output logic                 mem_r0_v_o,
   output logic                 mem_r1_v_o,

   // results, one cycle after the request
   output mem_pkg::word_t       r0_data_o,
   output logic                 r0_v_o,
   output mem_pkg::word_t       r1_data_o,
   output logic                 r1_v_o
);

   import mem_pkg::*;
   import operand_pkg::*;

   logic  [1:0] rd_v;
   addr_t       rd_addr [2];
   word_t       mem_data [2];
   logic  [1:0] mem_rd_v;
   logic  [1:0] res_v;
   word_t       res_data [2];

   // writes to register zero never reach the array
   assign mem_w_v_o = w_v_i && (w_addr_i != '0);

   assign rd_v[0]     = r0_v_i;
   assign rd_v[1]     = r1_v_i;
   assign rd_addr[0]  = r0_addr_i;
   assign rd_addr[1]  = r1_addr_i;
   assign mem_data[0] = mem_r0_data_i;
   assign mem_data[1] = mem_r1_data_i;

   assign mem_r0_v_o = mem_rd_v[0];
   assign mem_r1_v_o = mem_rd_v[1];
   assign r0_v_o     = res_v[0];
   assign r1_v_o     = res_v[1];
   assign r0_data_o  = res_data[0];
   assign r1_data_o  = res_data[1];

   for (genvar i = 0; i < 2; i++)
   begin : g_port

      src_sel_e sel_now;
      src_sel_e sel_r;
      word_t    byp_r;
      logic     v_r;

      // decided in the request cycle
      assign sel_now     = pick_src(rd_addr[i], w_v_i, w_addr_i);
      assign mem_rd_v[i] = rd_v[i] && (sel_now == SRC_MEM);

      // selection only moves on a strobe, so an idle port keeps its result
      always_ff @(posedge clk_i)
      begin
         if (rst_i)
         begin
            v_r   <= 1'b0;
            sel_r <= SRC_ZERO;
         end
         else
         begin
            v_r <= rd_v[i];
            if (rd_v[i])
            begin
               sel_r <= sel_now;
            end
         end
      end

      // capture the write data that the array is committing this edge
      always_ff @(posedge clk_i)
      begin
         if (rd_v[i] && (sel_now == SRC_BYPASS))
         begin
            byp_r <= w_data_i;
         end
      end

      always_comb
      begin
         unique case (sel_r)
            SRC_MEM:    res_data[i] = mem_data[i];
            SRC_BYPASS: res_data[i] = byp_r;
            default:    res_data[i] = '0;
         endcase
      end

      assign res_v[i] = v_r;

      a_no_strobe_collision : assert property (
         @(posedge clk_i) disable iff (rst_i)
         (mem_w_v_o && mem_rd_v[i]) |-> (rd_addr[i] != w_addr_i)
      )
      else $error("port %0d memory read collides with write %0h", i, w_addr_i);

      // relies on the array holding its read register too
      a_idle_holds_data : assert property (
         @(posedge clk_i) disable iff (rst_i)
         !rd_v[i] |=> $stable(res_data[i])
      )
      else $error("port %0d result changed without a read strobe", i);

   end

endmodule

`default_nettype wire

// ==== design/operand_fetch.sv ====
// operand-fetch top level
// bypass unit in front of a two-read one-write register array

`timescale 1ns/1ps
`default_nettype none

`include "rf_settings.svh"

module operand_fetch (
   input  wire logic            clk_i,
   input  wire logic            rst_i,

   input  wire logic            w_v_i,
   input  mem_pkg::addr_t       w_addr_i,
   input  mem_pkg::word_t       w_data_i,

   input  wire logic            r0_v_i,
   input  mem_pkg::addr_t       r0_addr_i,
   output mem_pkg::word_t       r0_data_o,
   output logic                 r0_v_o,

   input  wire logic            r1_v_i,
   input  mem_pkg::addr_t       r1_addr_i,
   output mem_pkg::word_t       r1_data_o,
   output logic                 r1_v_o
);

   import mem_pkg::*;

   // filtered strobes toward the array
   logic  mem_w_v;
   logic  mem_r0_v;
   logic  mem_r1_v;

   // array read registers back to the bypass unit
   word_t mem_r0_data;
   word_t mem_r1_data;

   operand_bypass bypass0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .w_v_i         (w_v_i),
      .w_addr_i      (w_addr_i),
      .w_data_i      (w_data_i),
      .r0_v_i        (r0_v_i),
      .r0_addr_i     (r0_addr_i),
      .r1_v_i        (r1_v_i),
      .r1_addr_i     (r1_addr_i),
      .mem_r0_data_i (mem_r0_data),
      .mem_r1_data_i (mem_r1_data),
      .mem_w_v_o     (mem_w_v),
      .mem_r0_v_o    (mem_r0_v),
      .mem_r1_v_o    (mem_r1_v),
      .r0_data_o     (r0_data_o),
      .r0_v_o        (r0_v_o),
      .r1_data_o     (r1_data_o),
      .r1_v_o        (r1_v_o)
   );

   // addresses and write data go straight to the array
   mem_2r1w_sync #(
      .width_p (`RF_WIDTH),
      .els_p   (`RF_ELS)
   ) mem0 (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .w_v_i     (mem_w_v),
      .w_addr_i  (w_addr_i),
      .w_data_i  (w_data_i),
      .r0_v_i    (mem_r0_v),
      .r0_addr_i (r0_addr_i),
      .r0_data_o (mem_r0_data),
      .r1_v_i    (mem_r1_v),
      .r1_addr_i (r1_addr_i),
      .r1_data_o (mem_r1_data)
   );

endmodule

`default_nettype wire

// ==== testbench/operand_fetch_tb.sv ====
// testbench for the operand-fetch block
// directed tests and random traffic checked against a register model

`timescale 1ns/1ps
`default_nettype none

`include "rf_settings.svh"

module operand_fetch_tb;

   import mem_pkg::*;

   localparam int timeout_cycles = 20;
   localparam int random_cycles  = 400;

   logic  clk_i;
   logic  rst_i;
   logic  w_v_i;
   addr_t w_addr_i;
   word_t w_data_i;
   logic  r0_v_i;
   addr_t r0_addr_i;
   word_t r0_data_o;
   logic  r0_v_o;
   logic  r1_v_i;
   addr_t r1_addr_i;
   word_t r1_data_o;
   logic  r1_v_o;

   // reference register values, register zero stays zero
   word_t model [`RF_ELS];

   // result each port should be holding
   word_t last0;
   word_t last1;
   int    seed_ret;

   operand_fetch dut0 (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .w_v_i     (w_v_i),
      .w_addr_i  (w_addr_i),
      .w_data_i  (w_data_i),
      .r0_v_i    (r0_v_i),
      .r0_addr_i (r0_addr_i),
      .r0_data_o (r0_data_o),
      .r0_v_o    (r0_v_o),
      .r1_v_i    (r1_v_i),
      .r1_addr_i (r1_addr_i),
      .r1_data_o (r1_data_o),
      .r1_v_o    (r1_v_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic check_value(input string sig, input word_t exp, input word_t act);
      if (act !== exp)
      begin
         $display("FAIL time=%0t %s expected %h actual %h", $time, sig, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic idle_inputs();
      w_v_i     = 1'b0;
      w_addr_i  = '0;
      w_data_i  = '0;
      r0_v_i    = 1'b0;
      r0_addr_i = '0;
      r1_v_i    = 1'b0;
      r1_addr_i = '0;
   endtask

   task automatic apply_write(input logic w_v, input addr_t w_a, input word_t w_d);
      if (w_v && (w_a != '0))
      begin
         model[w_a] = w_d;
      end
   endtask

   task automatic write_reg(input addr_t a, input word_t d);
      w_v_i    = 1'b1;
      w_addr_i = a;
      w_data_i = d;
      apply_write(1'b1, a, d);
      @(negedge clk_i);
      idle_inputs();
   endtask

   task automatic check_idle_outputs();
      check_value("r0_v_o", '0, word_t'(r0_v_o));
      check_value("r1_v_o", '0, word_t'(r1_v_o));
      check_value("r0_data_o", last0, r0_data_o);
      check_value("r1_data_o", last1, r1_data_o);
   endtask

   // both ports were strobed, result must arrive one cycle later
   task automatic wait_results();
      int cycles;
      @(negedge clk_i);
      idle_inputs();
      cycles = 1;
      while (!(r0_v_o && r1_v_o))
      begin
         if (cycles >= timeout_cycles)
         begin
            $display("timeout: no read result after %0d cycles", cycles);
            $display("Test failed");
            $fatal(1);
         end
         else
         begin
            @(negedge clk_i);
            cycles++;
         end
      end
      check_value("read latency", 32'd1, word_t'(cycles));
   endtask

   task automatic read_check(input addr_t a0, input addr_t a1, input logic w_v,
                             input addr_t w_a, input word_t w_d);
      word_t exp0;
      word_t exp1;
      r0_v_i    = 1'b1;
      r0_addr_i = a0;
      r1_v_i    = 1'b1;
      r1_addr_i = a1;
      w_v_i     = w_v;
      w_addr_i  = w_a;
      w_data_i  = w_d;
      // a write in the read cycle is already visible to the read
      apply_write(w_v, w_a, w_d);
      exp0      = model[a0];
      exp1      = model[a1];
      wait_results();
      check_value("r0_data_o", exp0, r0_data_o);
      check_value("r1_data_o", exp1, r1_data_o);
      last0 = exp0;
      last1 = exp1;
      // valid is a single pulse and data stays put
      @(negedge clk_i);
      check_idle_outputs();
   endtask

   task automatic test_reset_state();
      last0 = '0;
      last1 = '0;
      repeat (3)
      begin
         check_idle_outputs();
         @(negedge clk_i);
      end
   endtask

   task automatic test_write_then_read();
      int    i;
      word_t d;
      for (i = 1; i < `RF_ELS; i++)
      begin
         d = 32'h5a5a_0000 + word_t'(i) * 32'h0001_0011;
         write_reg(addr_t'(i), d);
      end
      for (i = 1; i < `RF_ELS; i++)
      begin
         read_check(addr_t'(i), addr_t'(`RF_ELS - i), 1'b0, '0, '0);
      end
   endtask

   task automatic test_same_cycle_bypass();
      int    k;
      addr_t a;
      word_t d;
      for (k = 0; k < 3; k++)
      begin
         a = addr_t'(5 + 13 * k);
         d = $urandom;
         read_check(a, a, 1'b1, a, d);
         // now from the array
         read_check(a, a, 1'b0, '0, '0);
      end
      d = $urandom;
      read_check(addr_t'(9), addr_t'(10), 1'b1, addr_t'(10), d);
      read_check(addr_t'(9), addr_t'(10), 1'b0, '0, '0);
      d = $urandom;
      read_check(addr_t'(2), addr_t'(3), 1'b1, addr_t'(12), d);
      read_check(addr_t'(12), addr_t'(12), 1'b0, '0, '0);
   endtask

   task automatic test_register_zero();
      write_reg('0, 32'hdead_beef);
      read_check('0, '0, 1'b0, '0, '0);
      read_check('0, '0, 1'b1, '0, 32'hffff_ffff);
      read_check('0, addr_t'(6), 1'b1, '0, 32'h1234_5678);
      read_check(addr_t'(6), '0, 1'b0, '0, '0);
   endtask

   task automatic test_hold_idle();
      int k;
      read_check(addr_t'(7), addr_t'(8), 1'b0, '0, '0);
      // array contents change underneath, outputs must not
      for (k = 0; k < 4; k++)
      begin
         write_reg(addr_t'(7 + k % 2), word_t'($urandom));
         check_idle_outputs();
         @(negedge clk_i);
         check_idle_outputs();
      end
      read_check(addr_t'(7), addr_t'(8), 1'b0, '0, '0);
   endtask

   task automatic test_random_traffic();
      int          n;
      logic [31:0] rnd;
      logic        w_v;
      addr_t       w_a;
      word_t       w_d;
      logic        v0;
      logic        v1;
      addr_t       a0;
      addr_t       a1;
      logic        exp_v0;
      logic        exp_v1;
      exp_v0 = 1'b0;
      exp_v1 = 1'b0;
      for (n = 0; n <= random_cycles; n++)
      begin
         check_value("r0_v_o", word_t'(exp_v0), word_t'(r0_v_o));
         check_value("r1_v_o", word_t'(exp_v1), word_t'(r1_v_o));
         check_value("r0_data_o", last0, r0_data_o);
         check_value("r1_data_o", last1, r1_data_o);
         if (n == random_cycles)
         begin
            idle_inputs();
         end
         else
         begin
            rnd = $urandom;
            w_d = $urandom;
            w_v = rnd[0];
            w_a = rnd[5:1];
            v0  = (rnd[7:6] != 2'b00);
            // a quarter of the reads aim at the write address
            a0  = (rnd[9:8] == 2'b00) ? w_a : rnd[14:10];
            v1  = (rnd[16:15] != 2'b00);
            a1  = (rnd[18:17] == 2'b00) ? w_a : rnd[23:19];
            apply_write(w_v, w_a, w_d);
            if (v0)
               last0 = model[a0];
            if (v1)
               last1 = model[a1];
            exp_v0 = v0;
            exp_v1 = v1;
            w_v_i     = w_v;
            w_addr_i  = w_a;
            w_data_i  = w_d;
            r0_v_i    = v0;
            r0_addr_i = a0;
            r1_v_i    = v1;
            r1_addr_i = a1;
            @(negedge clk_i);
         end
      end
   endtask

   initial
   begin
      idle_inputs();
      rst_i = 1'b1;
      foreach (model[i])
         model[i] = '0;
      last0    = '0;
      last1    = '0;
      seed_ret = $urandom(82516);
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      test_reset_state();
      test_write_then_read();
      test_same_cycle_bypass();
      test_register_zero();
      test_hold_idle();
      test_random_traffic();

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== operand_fetch.f ====
+incdir+design
design/mem_pkg.sv
design/operand_pkg.sv
design/mem_2r1w_sync.sv
design/operand_bypass.sv
design/operand_fetch.sv
testbench/operand_fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the operand-fetch testbench with Verilator and run it
# a $fatal in the testbench gives a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f operand_fetch.f \
   --top-module operand_fetch_tb \
   -o operand_fetch_sim

./obj_dir/operand_fetch_sim
